/* Bender.yml */
package:
  name: axi4_write_2d

sources:
  - files:
      - hw/axi4_write_2d_pkg.sv
      - hw/axi4_write_2d_line_gen.sv
      - hw/axi4_write_2d_burst_split.sv
      - hw/axi4_write_2d_tag_fifo.sv
      - hw/axi4_write_2d_wdata_gate.sv
      - hw/axi4_write_2d_back.sv
      - hw/axi4_write_2d.sv
  - target: test
    files:
      - tb/axi4_write_2d_tb.sv

/* axi4_write_2d.f */
hw/axi4_write_2d_pkg.sv
hw/axi4_write_2d_line_gen.sv
hw/axi4_write_2d_burst_split.sv
hw/axi4_write_2d_tag_fifo.sv
hw/axi4_write_2d_wdata_gate.sv
hw/axi4_write_2d_back.sv
hw/axi4_write_2d.sv
tb/axi4_write_2d_tb.sv

/* hw/axi4_write_2d.sv */
`timescale 1ns/1ps

module axi4_write_2d (
    input  logic                                     aclk,
    input  logic                                     rst_n,

    input  axi4_write_2d_pkg::frame_cmd_t            s_cmd,
    input  logic                                     s_cmd_valid,
    output logic                                     s_cmd_ready,

    input  logic [axi4_write_2d_pkg::DATA_WIDTH-1:0] s_wdata,
    input  logic                                     s_wvalid,
    output logic                                     s_wready,

    output axi4_write_2d_pkg::line_ack_t             s_back,
    output logic                                     s_back_valid,
    input  logic                                     s_back_ready,

    output axi4_write_2d_pkg::aw_beat_t              m_aw,
    output logic                                     m_aw_valid,
    input  logic                                     m_aw_ready,

    output logic [axi4_write_2d_pkg::DATA_WIDTH-1:0] m_wdata,
    output logic                                     m_wlast,
    output logic                                     m_wvalid,
    input  logic                                     m_wready,

    input  axi4_write_2d_pkg::axi_resp_e             m_bresp,
    input  logic                                     m_bvalid,
    output logic                                     m_bready
);
    import axi4_write_2d_pkg::*;

    line_cmd_t line;
    logic      line_valid;
    logic      line_ready;

    logic      len_push;
    logic      len_full;
    aw_beat_t  len_head;
    logic      len_valid;
    logic      len_pop;

    ack_tag_t  tag_in;
    logic      tag_push;
    logic      tag_full;
    ack_tag_t  tag_head;
    logic      tag_valid;
    logic      tag_pop;

    // ----------------------------------------------------------------------
    //  command side
    // ----------------------------------------------------------------------

    axi4_write_2d_line_gen u_line_gen (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_cmd        (s_cmd),
        .s_cmd_valid  (s_cmd_valid),
        .s_cmd_ready  (s_cmd_ready),
        .m_line       (line),
        .m_line_valid (line_valid),
        .m_line_ready (line_ready)
    );

    axi4_write_2d_burst_split u_burst_split (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_line       (line),
        .s_line_valid (line_valid),
        .s_line_ready (line_ready),
        .m_aw         (m_aw),
        .m_aw_valid   (m_aw_valid),
        .m_aw_ready   (m_aw_ready),
        .len_push     (len_push),
        .len_full     (len_full),
        .tag          (tag_in),
        .tag_push     (tag_push),
        .tag_full     (tag_full)
    );

    // ----------------------------------------------------------------------
    //  burst queues
    // ----------------------------------------------------------------------

    axi4_write_2d_tag_fifo #(.elem_t(aw_beat_t)) u_len_fifo (
        .aclk  (aclk),
        .rst_n (rst_n),
        .push  (len_push),
        .din   (m_aw),
        .full  (len_full),
        .dout  (len_head),
        .valid (len_valid),
        .pop   (len_pop)
    );

    axi4_write_2d_tag_fifo #(.elem_t(ack_tag_t)) u_tag_fifo (
        .aclk  (aclk),
        .rst_n (rst_n),
        .push  (tag_push),
        .din   (tag_in),
        .full  (tag_full),
        .dout  (tag_head),
        .valid (tag_valid),
        .pop   (tag_pop)
    );

    // ----------------------------------------------------------------------
    //  W and B side
    // ----------------------------------------------------------------------

    axi4_write_2d_wdata_gate u_wdata_gate (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .s_len       (len_head),
        .s_len_valid (len_valid),
        .s_len_ready (len_pop),
        .s_wdata     (s_wdata),
        .s_wvalid    (s_wvalid),
        .s_wready    (s_wready),
        .m_wdata     (m_wdata),
        .m_wlast     (m_wlast),
        .m_wvalid    (m_wvalid),
        .m_wready    (m_wready)
    );

    axi4_write_2d_back u_back (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_tag        (tag_head),
        .s_tag_valid  (tag_valid),
        .s_tag_ready  (tag_pop),
        .m_bresp      (m_bresp),
        .m_bvalid     (m_bvalid),
        .m_bready     (m_bready),
        .m_back       (s_back),
        .m_back_valid (s_back_valid),
        .m_back_ready (s_back_ready)
    );

endmodule

/* hw/axi4_write_2d_back.sv */
`timescale 1ns/1ps

module axi4_write_2d_back (
    input  logic                          aclk,
    input  logic                          rst_n,

    input  axi4_write_2d_pkg::ack_tag_t   s_tag,
    input  logic                          s_tag_valid,
    output logic                          s_tag_ready,

    input  axi4_write_2d_pkg::axi_resp_e  m_bresp,
    input  logic                          m_bvalid,
    output logic                          m_bready,

    output axi4_write_2d_pkg::line_ack_t  m_back,
    output logic                          m_back_valid,
    input  logic                          m_back_ready
);
    import axi4_write_2d_pkg::*;

    logic err_q;
    logic b_fire;
    logic b_bad;

    assign m_bready    = s_tag_valid && (!m_back_valid || m_back_ready);
    assign b_fire      = m_bvalid && m_bready;
    assign s_tag_ready = b_fire;
    assign b_bad       = (m_bresp != OKAY);

    // sticky error across the bursts of one line
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            err_q        <= 1'b0;
            m_back_valid <= 1'b0;
        end else begin
            if (m_back_ready) begin
                m_back_valid <= 1'b0;
            end
            if (b_fire) begin
                if (s_tag.last_burst) begin
                    err_q        <= 1'b0;
                    m_back_valid <= 1'b1;
                end else begin
                    err_q <= err_q || b_bad;
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (b_fire && s_tag.last_burst) begin
            m_back.first_line <= s_tag.first_line;
            m_back.last_line  <= s_tag.last_line;
            m_back.error      <= err_q || b_bad;
        end
    end

endmodule

/* hw/axi4_write_2d_burst_split.sv */
`timescale 1ns/1ps

module axi4_write_2d_burst_split (
    input  logic                         aclk,
    input  logic                         rst_n,

    input  axi4_write_2d_pkg::line_cmd_t s_line,
    input  logic                         s_line_valid,
    output logic                         s_line_ready,

    output axi4_write_2d_pkg::aw_beat_t  m_aw,
    output logic                         m_aw_valid,
    input  logic                         m_aw_ready,

    output logic                         len_push,
    input  logic                         len_full,

    output axi4_write_2d_pkg::ack_tag_t  tag,
    output logic                         tag_push,
    input  logic                         tag_full
);
    import axi4_write_2d_pkg::*;

    split_state_e              state;
    logic [ADDR_WIDTH-1:0]     cur_addr;
    logic [LINE_LEN_WIDTH-1:0] remain;
    logic                      first_q;
    logic                      last_q;
    logic                      aw_held;
    logic                      aw_fire;
    logic                      load;
    logic                      line_done;
    logic [LINE_LEN_WIDTH-1:0] bound_beats;
    logic [LINE_LEN_WIDTH-1:0] burst_beats;

    // AW goes out only while both queues can take the push
    assign m_aw_valid   = aw_held && !len_full && !tag_full;
    assign aw_fire      = m_aw_valid && m_aw_ready;
    assign len_push     = aw_fire;
    assign tag_push     = aw_fire;
    assign s_line_ready = (state == SPLIT_IDLE);
    assign load         = (state == SPLIT_ISSUE) && (!aw_held || aw_fire);
    assign line_done    = (burst_beats == remain);

    // ----------------------------------------------------------------------
    //  burst size
    // ----------------------------------------------------------------------

    always_comb begin
        bound_beats = LINE_LEN_WIDTH'((BOUNDARY_BYTES
                      - int'(cur_addr[BOUNDARY_BITS-1:0])) / BEAT_BYTES);
        burst_beats = remain;
        if (burst_beats > LINE_LEN_WIDTH'(MAX_BURST_BEATS)) begin
            burst_beats = LINE_LEN_WIDTH'(MAX_BURST_BEATS);
        end
        // stop short of the 4 KB boundary
        if (burst_beats > bound_beats) begin
            burst_beats = bound_beats;
        end
    end

    // ----------------------------------------------------------------------
    //  FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state   <= SPLIT_IDLE;
            aw_held <= 1'b0;
        end else begin
            if (load) begin
                aw_held <= 1'b1;
            end else if (aw_fire) begin
                aw_held <= 1'b0;
            end
            case (state)
                SPLIT_IDLE:  if (s_line_valid) state <= SPLIT_ISSUE;
                SPLIT_ISSUE: if (load && line_done) state <= SPLIT_IDLE;
                default:     state <= SPLIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (s_line_valid && s_line_ready) begin
            cur_addr <= s_line.addr;
            remain   <= s_line.line_len;
            first_q  <= s_line.first_line;
            last_q   <= s_line.last_line;
        end else if (load) begin
            cur_addr <= cur_addr + ADDR_WIDTH'(burst_beats * BEAT_BYTES);
            remain   <= remain - burst_beats;
        end
        if (load) begin
            m_aw.addr      <= cur_addr;
            m_aw.len       <= LEN_WIDTH'(burst_beats - 1'b1);
            tag.last_burst <= line_done;
            tag.first_line <= first_q;
            tag.last_line  <= last_q;
        end
    end

    a_aw_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw));

endmodule

/* hw/axi4_write_2d_line_gen.sv */
`timescale 1ns/1ps

module axi4_write_2d_line_gen (
    input  logic                          aclk,
    input  logic                          rst_n,

    input  axi4_write_2d_pkg::frame_cmd_t s_cmd,
    input  logic                          s_cmd_valid,
    output logic                          s_cmd_ready,

    output axi4_write_2d_pkg::line_cmd_t  m_line,
    output logic                          m_line_valid,
    input  logic                          m_line_ready
);
    import axi4_write_2d_pkg::*;

    logic [STEP_WIDTH-1:0]     step_q;
    logic [LINE_NUM_WIDTH-1:0] lines_left;
    logic                      cmd_fire;
    logic                      line_fire;

    assign cmd_fire  = s_cmd_valid && s_cmd_ready;
    assign line_fire = m_line_valid && m_line_ready;

    // one frame at a time
    assign s_cmd_ready = !m_line_valid;

    // ----------------------------------------------------------------------
    //  control
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_line_valid <= 1'b0;
        end else if (cmd_fire) begin
            m_line_valid <= 1'b1;
        end else if (line_fire && m_line.last_line) begin
            m_line_valid <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    //  line address and counter
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (cmd_fire) begin
            m_line.addr       <= s_cmd.addr;
            m_line.line_len   <= s_cmd.line_len;
            m_line.first_line <= 1'b1;
            m_line.last_line  <= (s_cmd.line_num == LINE_NUM_WIDTH'(1));
            step_q            <= s_cmd.step;
            lines_left        <= s_cmd.line_num - 1'b1;
        end else if (line_fire) begin
            // next line starts one stride further on
            m_line.addr       <= m_line.addr + ADDR_WIDTH'(step_q);
            m_line.first_line <= 1'b0;
            m_line.last_line  <= (lines_left == LINE_NUM_WIDTH'(1));
            lines_left        <= lines_left - 1'b1;
        end
    end

endmodule

/* hw/axi4_write_2d_pkg.sv */
package axi4_write_2d_pkg;

    // ----------------------------------------------------------------------
    //  bus and command widths
    // ----------------------------------------------------------------------

    localparam int ADDR_WIDTH     = 32;
    localparam int DATA_WIDTH     = 32;
    localparam int BEAT_BYTES     = DATA_WIDTH / 8;
    localparam int LEN_WIDTH      = 8;
    localparam int STEP_WIDTH     = 16;
    localparam int LINE_LEN_WIDTH = 16;
    localparam int LINE_NUM_WIDTH = 12;

    // burst limits
    localparam int MAX_BURST_BEATS = 16;
    localparam int BOUNDARY_BYTES  = 4096;
    localparam int BOUNDARY_BITS   = $clog2(BOUNDARY_BYTES);

    localparam int TAG_FIFO_DEPTH = 16;

    // ----------------------------------------------------------------------
    //  command and status types
    // ----------------------------------------------------------------------

    // step is in bytes, line_len in beats, neither may be zero
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     addr;
        logic [STEP_WIDTH-1:0]     step;
        logic [LINE_LEN_WIDTH-1:0] line_len;
        logic [LINE_NUM_WIDTH-1:0] line_num;
    } frame_cmd_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     addr;
        logic [LINE_LEN_WIDTH-1:0] line_len;
        logic                      first_line;
        logic                      last_line;
    } line_cmd_t;

    // len is beats minus one, as on awlen
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [LEN_WIDTH-1:0]  len;
    } aw_beat_t;

    typedef struct packed {
        logic last_burst;
        logic first_line;
        logic last_line;
    } ack_tag_t;

    typedef struct packed {
        logic first_line;
        logic last_line;
        logic error;
    } line_ack_t;

    typedef enum logic {
        SPLIT_IDLE,
        SPLIT_ISSUE
    } split_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

/* hw/axi4_write_2d_tag_fifo.sv */
`timescale 1ns/1ps

module axi4_write_2d_tag_fifo #(
    parameter type elem_t = axi4_write_2d_pkg::ack_tag_t
) (
    input  logic  aclk,
    input  logic  rst_n,

    input  logic  push,
    input  elem_t din,
    output logic  full,

    output elem_t dout,
    output logic  valid,
    input  logic  pop
);
    import axi4_write_2d_pkg::*;

    elem_t                               mem [TAG_FIFO_DEPTH];
    logic [$clog2(TAG_FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(TAG_FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(TAG_FIFO_DEPTH):0]     count;

    assign dout  = mem[rd_ptr];
    assign valid = (count != '0);
    assign full  = (count == ($clog2(TAG_FIFO_DEPTH)+1)'(TAG_FIFO_DEPTH));

    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + push - pop;
        end
    end

    // callers qualify push with full and pop with valid
    a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n)
        !(push && full) && !(pop && !valid));

endmodule

/* hw/axi4_write_2d_wdata_gate.sv */
`timescale 1ns/1ps

module axi4_write_2d_wdata_gate (
    input  logic                                     aclk,
    input  logic                                     rst_n,

    input  axi4_write_2d_pkg::aw_beat_t              s_len,
    input  logic                                     s_len_valid,
    output logic                                     s_len_ready,

    input  logic [axi4_write_2d_pkg::DATA_WIDTH-1:0] s_wdata,
    input  logic                                     s_wvalid,
    output logic                                     s_wready,

    output logic [axi4_write_2d_pkg::DATA_WIDTH-1:0] m_wdata,
    output logic                                     m_wlast,
    output logic                                     m_wvalid,
    input  logic                                     m_wready
);
    import axi4_write_2d_pkg::*;

    logic [LEN_WIDTH-1:0] beat_cnt;
    logic                 w_fire;

    // ----------------------------------------------------------------------
    //  beat pass-through
    // ----------------------------------------------------------------------

    // data moves only while a burst is open at the queue head
    assign m_wdata  = s_wdata;
    assign m_wvalid = s_wvalid && s_len_valid;
    assign s_wready = m_wready && s_len_valid;
    assign m_wlast  = m_wvalid && (beat_cnt == s_len.len);
    assign w_fire   = m_wvalid && m_wready;

    // final beat closes the burst
    assign s_len_ready = w_fire && m_wlast;

    // ----------------------------------------------------------------------
    //  beat counter
    // ----------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            if (m_wlast) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    a_wlast_valid: assert property (@(posedge aclk) disable iff (!rst_n)
        m_wlast |-> m_wvalid);

endmodule

/* tb/axi4_write_2d_tb.sv */
`timescale 1ns/1ps

module axi4_write_2d_tb;
    import axi4_write_2d_pkg::*;

    localparam int          CMD_TIMEOUT = 200;
    localparam int          ACK_TIMEOUT = 5000;
    localparam int          NUM_FRAMES  = 6;
    localparam logic [31:0] NO_ERR      = 32'hffff_fff0;

    typedef struct {
        string       name;
        logic [31:0] addr;
        logic [15:0] step;
        int          line_len;
        int          line_num;
        bit          stall;
        logic [31:0] err_addr;
        int          exp_bursts;
        int          err_line;
    } frame_t;

    logic                  aclk = 1'b0;
    logic                  rst_n;
    frame_cmd_t            s_cmd;
    logic                  s_cmd_valid;
    logic                  s_cmd_ready;
    logic [DATA_WIDTH-1:0] s_wdata;
    logic                  s_wvalid;
    logic                  s_wready;
    line_ack_t             s_back;
    logic                  s_back_valid;
    logic                  s_back_ready;
    aw_beat_t              m_aw;
    logic                  m_aw_valid;
    logic                  m_aw_ready;
    logic [DATA_WIDTH-1:0] m_wdata;
    logic                  m_wlast;
    logic                  m_wvalid;
    logic                  m_wready;
    axi_resp_e             m_bresp;
    logic                  m_bvalid;
    logic                  m_bready;

    frame_t      frames [NUM_FRAMES];
    logic [31:0] mem [0:16383];
    aw_beat_t    aw_q[$];
    aw_beat_t    aw_log[$];
    aw_beat_t    exp_aw[$];
    logic [31:0] wd_q[$];
    logic        wl_q[$];
    axi_resp_e   b_q[$];
    line_ack_t   ack_q[$];
    string       cur_name = "";
    bit          stall = 1'b0;
    logic [31:0] err_addr = NO_ERR;
    int          w_left = 0;
    logic [31:0] next_word = 32'h0000_1000;
    bit          w_fired = 1'b0;
    bit          b_fired = 1'b0;
    int          frame_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    always #20 aclk = ~aclk;

    axi4_write_2d axi4_write_2d_i (.*);

    task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("Fail %s: %s expected %0h actual %0h", cur_name, what, exp_val, act_val);
        frame_errs++;
    endtask

    // ----------------------------------------------------------------------
    //  AXI4 slave memory model
    // ----------------------------------------------------------------------

    // pair each AW with its W beats once both have arrived
    task automatic commit_bursts();
        aw_beat_t    a;
        logic [31:0] d;
        logic [31:0] addr;
        logic        last;
        bit          bad;
        while (aw_q.size() > 0 && wd_q.size() > int'(aw_q[0].len)) begin
            a = aw_q.pop_front();
            bad = 1'b0;
            for (int i = 0; i <= int'(a.len); i++) begin
                d = wd_q.pop_front();
                last = wl_q.pop_front();
                addr = a.addr + 32'(i * BEAT_BYTES);
                mem[addr[15:2]] = d;
                if (addr == err_addr) bad = 1'b1;
                if (last != (i == int'(a.len))) begin
                    report_mismatch($sformatf("wlast at %0h", addr), i == int'(a.len), last);
                end
            end
            if (bad) begin
                b_q.push_back(SLVERR);
            end else begin
                b_q.push_back(OKAY);
            end
        end
    endtask

    // transfers are taken from the values held just before the edge
    always @(posedge aclk) begin
        if (rst_n) begin
            if (m_aw_valid && m_aw_ready) begin
                aw_q.push_back(m_aw);
                aw_log.push_back(m_aw);
            end
            if (m_wvalid && m_wready) begin
                wd_q.push_back(m_wdata);
                wl_q.push_back(m_wlast);
            end
            if (s_wvalid && s_wready) begin
                next_word++;
                w_left--;
                w_fired = 1'b1;
            end
            if (m_bvalid && m_bready) begin
                void'(b_q.pop_front());
                b_fired = 1'b1;
            end
            if (s_back_valid && s_back_ready) ack_q.push_back(s_back);
            commit_bursts();
        end
    end

    // caller data, readies and B responses change on the falling edge
    initial begin
        m_aw_ready   = 1'b0;
        s_wdata      = '0;
        s_wvalid     = 1'b0;
        m_wready     = 1'b0;
        m_bresp      = OKAY;
        m_bvalid     = 1'b0;
        s_back_ready = 1'b0;
        void'($urandom(1));
        forever begin
            @(negedge aclk);
            m_aw_ready   = !stall || ($urandom % 4 != 0);
            m_wready     = !stall || ($urandom % 4 != 0);
            s_back_ready = !stall || ($urandom % 4 != 0);
            // a raised valid holds until its transfer
            if (!s_wvalid || w_fired) begin
                s_wvalid = (w_left > 0) && (!stall || ($urandom % 4 != 0));
                s_wdata  = next_word;
            end
            w_fired = 1'b0;
            if (!m_bvalid || b_fired) begin
                m_bvalid = (b_q.size() > 0) && (!stall || ($urandom % 4 != 0));
                if (m_bvalid) m_bresp = b_q[0];
            end
            b_fired = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    //  expected bursts and frame runner
    // ----------------------------------------------------------------------

    task automatic predict_bursts(input frame_t f);
        logic [31:0] a;
        int          left;
        int          n;
        int          to_bound;
        exp_aw.delete();
        for (int l = 0; l < f.line_num; l++) begin
            a = f.addr + 32'(l) * 32'(f.step);
            left = f.line_len;
            while (left > 0) begin
                to_bound = (BOUNDARY_BYTES - int'(a % BOUNDARY_BYTES)) / BEAT_BYTES;
                n = (left < MAX_BURST_BEATS) ? left : MAX_BURST_BEATS;
                if (n > to_bound) n = to_bound;
                exp_aw.push_back('{addr: a, len: 8'(n - 1)});
                a = a + 32'(n * BEAT_BYTES);
                left = left - n;
            end
        end
    endtask

    task automatic run_frame(input frame_t f);
        logic [31:0] base;
        logic [31:0] a;
        logic [31:0] exp_word;
        line_ack_t   exp_ack;
        int          t;
        bit          mem_bad;
        @(posedge aclk);
        cur_name = f.name;
        stall = f.stall;
        err_addr = f.err_addr;
        frame_errs = 0;
        aw_log.delete();
        ack_q.delete();
        base = next_word;
        w_left = f.line_len * f.line_num;
        predict_bursts(f);
        @(negedge aclk);
        s_cmd.addr = f.addr;
        s_cmd.step = f.step;
        s_cmd.line_len = LINE_LEN_WIDTH'(f.line_len);
        s_cmd.line_num = LINE_NUM_WIDTH'(f.line_num);
        s_cmd_valid = 1'b1;
        for (t = 0; t < CMD_TIMEOUT; t++) begin
            @(posedge aclk);
            if (s_cmd_ready) break;
        end
        if (t == CMD_TIMEOUT) begin
            $display("timeout: the engine never took the command of %s", f.name);
            $display("sim failed");
            $finish;
        end
        @(negedge aclk);
        s_cmd_valid = 1'b0;
        for (t = 0; t < ACK_TIMEOUT; t++) begin
            @(negedge aclk);
            if (ack_q.size() >= f.line_num) break;
        end
        if (t == ACK_TIMEOUT) begin
            $display("timeout: %s got %0d of %0d line acks", f.name, ack_q.size(), f.line_num);
            $display("sim failed");
            $finish;
        end
        // short window to catch surplus bursts or acks
        repeat (8) @(negedge aclk);

        if (aw_log.size() != f.exp_bursts) begin
            report_mismatch("burst count", f.exp_bursts, aw_log.size());
        end else begin
            foreach (aw_log[i]) begin
                if (aw_log[i] !== exp_aw[i]) report_mismatch($sformatf("aw %0d", i),
                                                             exp_aw[i], aw_log[i]);
            end
        end
        mem_bad = 1'b0;
        for (int l = 0; l < f.line_num && !mem_bad; l++) begin
            for (int b = 0; b < f.line_len && !mem_bad; b++) begin
                a = f.addr + 32'(l) * 32'(f.step) + 32'(b * BEAT_BYTES);
                exp_word = base + 32'(l * f.line_len + b);
                if (mem[a[15:2]] !== exp_word) begin
                    report_mismatch($sformatf("mem[%0h]", a), exp_word, mem[a[15:2]]);
                    mem_bad = 1'b1;
                end
            end
        end
        if (ack_q.size() != f.line_num) report_mismatch("ack count", f.line_num, ack_q.size());
        for (int l = 0; l < f.line_num && l < ack_q.size(); l++) begin
            exp_ack.first_line = (l == 0);
            exp_ack.last_line  = (l == f.line_num - 1);
            exp_ack.error      = (l == f.err_line);
            if (ack_q[l] !== exp_ack) report_mismatch($sformatf("ack %0d", l), exp_ack, ack_q[l]);
        end
        if (frame_errs == 0) begin
            $display("pass %s", f.name);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // ----------------------------------------------------------------------
    //  frame table and main sequence
    // ----------------------------------------------------------------------

    initial begin
        rst_n = 1'b0;
        s_cmd = '0;
        s_cmd_valid = 1'b0;
        frames[0] = '{"single_line", 32'h0000_0100, 16'h0000, 8, 1, 1'b0, NO_ERR, 1, -1};
        frames[1] = '{"split_40", 32'h0000_0400, 16'h0000, 40, 1, 1'b0, NO_ERR, 3, -1};
        frames[2] = '{"boundary", 32'h0000_0ff4, 16'h0000, 20, 1, 1'b0, NO_ERR, 3, -1};
        frames[3] = '{"multi_line", 32'h0000_2000, 16'h0100, 24, 4, 1'b0, NO_ERR, 8, -1};
        frames[4] = '{"stalled", 32'h0000_3fc0, 16'h0140, 36, 3, 1'b1, NO_ERR, 9, -1};
        frames[5] = '{"error_mid", 32'h0000_5000, 16'h0100, 40, 3, 1'b0, 32'h0000_5150, 9, 1};
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            run_frame(frames[i]);
        end
        $display("%0d tests, %0d passed, %0d failed", NUM_FRAMES, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
